// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_soc_fabric
RTL_TOP    := soc_fabric
FILELIST   := all.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+src
src/fabric_pkg.sv
src/addr_decode.sv
src/target_exec.sv
src/rsp_result.sv
src/soc_fabric.sv
testbench/soc_fabric_chk.sv
testbench/tb_soc_fabric.sv

// ==== src/addr_decode.sv ====
// Request queue and address decoder
`timescale 1ns/1ps

module addr_decode (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_valid_i,
  input  fabric_pkg::op_e                 req_op_i,
  input  fabric_pkg::addr_t               req_addr_i,
  input  fabric_pkg::data_t               req_wdata_i,
  input  fabric_pkg::be_t                 req_be_i,
  input  logic                            issue_ok_i,
  output logic                            req_credit_o,
  output logic                            dec_valid_o,
  output fabric_pkg::op_e                 dec_op_o,
  output fabric_pkg::target_e             dec_target_o,
  output logic [fabric_pkg::IdxWidth-1:0] dec_index_o,
  output fabric_pkg::data_t               dec_wdata_o,
  output fabric_pkg::be_t                 dec_be_o
);
  import fabric_pkg::*;

  op_e                    q_op    [ReqCredits];
  addr_t                  q_addr  [ReqCredits];
  data_t                  q_wdata [ReqCredits];
  be_t                    q_be    [ReqCredits];
  logic [ReqPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [ReqCntWidth-1:0] cnt_q;
  logic                   pop, pop_q;
  addr_t                  head_addr, head_off;
  target_e                head_tgt;

  // Never pop in the cycle of the push
  assign pop = (cnt_q != '0) && issue_ok_i;

  // ----------------------------------------
  // Address map decode on the queue head
  // ----------------------------------------
  assign head_addr = q_addr[rd_ptr_q];

  always_comb begin
    if (head_addr >= RomBase && head_addr < RomEnd) begin
      head_tgt = TGT_ROM;
      head_off = head_addr - RomBase;
    end else if (head_addr >= DramBase && head_addr < DramEnd) begin
      head_tgt = TGT_DRAM;
      head_off = head_addr - DramBase;
    end else begin
      head_tgt = TGT_ERR;
      head_off = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      pop_q    <= 1'b0;
    end else begin
      if (req_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + ReqCntWidth'(req_valid_i) - ReqCntWidth'(pop);
      pop_q <= pop;
    end
  end

  // Queue storage and decoded request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      q_op[wr_ptr_q]    <= req_op_i;
      q_addr[wr_ptr_q]  <= req_addr_i;
      q_wdata[wr_ptr_q] <= req_wdata_i;
      q_be[wr_ptr_q]    <= req_be_i;
    end
    if (pop) begin
      dec_op_o     <= q_op[rd_ptr_q];
      dec_target_o <= head_tgt;
      dec_index_o  <= head_off[ByteOffW +: IdxWidth];
      dec_wdata_o  <= q_wdata[rd_ptr_q];
      dec_be_o     <= q_be[rd_ptr_q];
    end
  end

  // One credit back per request leaving the queue
  assign req_credit_o = pop_q;
  assign dec_valid_o  = pop_q;

endmodule

// ==== src/bootrom_image.svh ====
// Boot ROM contents

// Word i sits at RomBase + 8*i
localparam fabric_pkg::data_t BOOTROM_IMAGE [fabric_pkg::RomWords] = '{
  64'h0000_0297_0202_8293,
  64'h0102_b283_f140_2573,
  64'h0000_0597_0405_8593,
  64'h0002_8067_0000_0013,
  64'h8000_0000_0000_0000,
  64'h0001_0040_0000_0000,
  64'hdead_beef_cafe_f00d,
  64'h1234_5678_9abc_def0
};

// ==== src/fabric_pkg.sv ====
// Memory fabric definitions
package fabric_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned ByteOffW  = $clog2(BeWidth);
  localparam int unsigned IdxWidth  = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam addr_t       RomBase    = 32'h0001_0000;
  localparam int unsigned RomWords   = 8;
  localparam int unsigned RomIdxW    = $clog2(RomWords);
  localparam addr_t       RomEnd     = RomBase + addr_t'(RomWords * BeWidth);
  localparam addr_t       DramBase   = 32'h8000_0000;
  localparam int unsigned DramWords  = 256;
  localparam addr_t       DramEnd    = DramBase + addr_t'(DramWords * BeWidth);

  // ----------------------------------------
  // Credits
  // ----------------------------------------
  localparam int unsigned ReqCredits  = 4;
  localparam int unsigned ReqPtrWidth = $clog2(ReqCredits);
  localparam int unsigned ReqCntWidth = $clog2(ReqCredits + 1);
  localparam int unsigned RspCredits  = 2;
  localparam int unsigned RspCntWidth = $clog2(RspCredits + 1);

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } op_e;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_DRAM,
    TGT_ERR
  } target_e;

  // AXI response encoding
  typedef enum logic [1:0] {
    RSP_OKAY   = 2'b00,
    RSP_SLVERR = 2'b10,
    RSP_DECERR = 2'b11
  } rsp_e;

endpackage

// ==== src/rsp_result.sv ====
// Response credits and result register
`timescale 1ns/1ps

module rsp_result (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                exe_valid_i,
  input  fabric_pkg::target_e exe_target_i,
  input  fabric_pkg::op_e     exe_op_i,
  input  fabric_pkg::data_t   exe_rdata_i,
  input  logic                rsp_credit_i,
  output logic                issue_ok_o,
  output logic                rsp_valid_o,
  output fabric_pkg::rsp_e    rsp_code_o,
  output fabric_pkg::data_t   rsp_rdata_o
);
  import fabric_pkg::*;

  logic [RspCntWidth-1:0] cred_q;
  logic [RspCntWidth-1:0] reserved;
  logic                   issue_ok_q;
  rsp_e                   code;

  // A pop may have happened last edge and the one before is in exe now
  assign reserved   = RspCntWidth'(exe_valid_i) + RspCntWidth'(issue_ok_q);
  assign issue_ok_o = cred_q > reserved;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cred_q      <= RspCntWidth'(RspCredits);
      issue_ok_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      cred_q      <= cred_q - RspCntWidth'(exe_valid_i) + RspCntWidth'(rsp_credit_i);
      issue_ok_q  <= issue_ok_o;
      rsp_valid_o <= exe_valid_i;
    end
  end

  // ----------------------------------------
  // Response code and data
  // ----------------------------------------
  always_comb begin
    if (exe_target_i == TGT_ERR) begin
      code = RSP_DECERR;
    end else if (exe_target_i == TGT_ROM && exe_op_i == OP_WRITE) begin
      code = RSP_SLVERR;
    end else begin
      code = RSP_OKAY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_valid_i) begin
      rsp_code_o  <= code;
      rsp_rdata_o <= (code == RSP_OKAY && exe_op_i == OP_READ) ? exe_rdata_i : '0;
    end
  end

endmodule

// ==== src/soc_fabric.sv ====
// Request/response fabric top level
`timescale 1ns/1ps

module soc_fabric (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  fabric_pkg::op_e   req_op_i,
  input  fabric_pkg::addr_t req_addr_i,
  input  fabric_pkg::data_t req_wdata_i,
  input  fabric_pkg::be_t   req_be_i,
  output logic              req_credit_o,
  output logic              rsp_valid_o,
  output fabric_pkg::rsp_e  rsp_code_o,
  output fabric_pkg::data_t rsp_rdata_o,
  input  logic              rsp_credit_i
);
  import fabric_pkg::*;

  logic                issue_ok;
  logic                dec_valid;
  op_e                 dec_op;
  target_e             dec_target;
  logic [IdxWidth-1:0] dec_index;
  data_t               dec_wdata;
  be_t                 dec_be;
  logic                exe_valid;
  target_e             exe_target;
  op_e                 exe_op;
  data_t               exe_rdata;

  addr_decode u_decode (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_op_i     ( req_op_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_be_i     ( req_be_i     ),
    .issue_ok_i   ( issue_ok     ),
    .req_credit_o ( req_credit_o ),
    .dec_valid_o  ( dec_valid    ),
    .dec_op_o     ( dec_op       ),
    .dec_target_o ( dec_target   ),
    .dec_index_o  ( dec_index    ),
    .dec_wdata_o  ( dec_wdata    ),
    .dec_be_o     ( dec_be       )
  );

  target_exec u_exec (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .dec_valid_i  ( dec_valid  ),
    .dec_op_i     ( dec_op     ),
    .dec_target_i ( dec_target ),
    .dec_index_i  ( dec_index  ),
    .dec_wdata_i  ( dec_wdata  ),
    .dec_be_i     ( dec_be     ),
    .exe_valid_o  ( exe_valid  ),
    .exe_target_o ( exe_target ),
    .exe_op_o     ( exe_op     ),
    .exe_rdata_o  ( exe_rdata  )
  );

  rsp_result u_result (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .exe_valid_i  ( exe_valid    ),
    .exe_target_i ( exe_target   ),
    .exe_op_i     ( exe_op       ),
    .exe_rdata_i  ( exe_rdata    ),
    .rsp_credit_i ( rsp_credit_i ),
    .issue_ok_o   ( issue_ok     ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_code_o   ( rsp_code_o   ),
    .rsp_rdata_o  ( rsp_rdata_o  )
  );

endmodule

// ==== src/target_exec.sv ====
// DRAM bank and boot ROM access
`timescale 1ns/1ps

module target_exec (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            dec_valid_i,
  input  fabric_pkg::op_e                 dec_op_i,
  input  fabric_pkg::target_e             dec_target_i,
  input  logic [fabric_pkg::IdxWidth-1:0] dec_index_i,
  input  fabric_pkg::data_t               dec_wdata_i,
  input  fabric_pkg::be_t                 dec_be_i,
  output logic                            exe_valid_o,
  output fabric_pkg::target_e             exe_target_o,
  output fabric_pkg::op_e                 exe_op_o,
  output fabric_pkg::data_t               exe_rdata_o
);
  import fabric_pkg::*;

  `include "bootrom_image.svh"

  data_t dram_q [DramWords];
  data_t rdata;
  logic  dram_we;

  assign dram_we = dec_valid_i && (dec_target_i == TGT_DRAM) && (dec_op_i == OP_WRITE);

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_comb begin
    case (dec_target_i)
      TGT_ROM:  rdata = BOOTROM_IMAGE[dec_index_i[RomIdxW-1:0]];
      TGT_DRAM: rdata = dram_q[dec_index_i];
      default:  rdata = '0;
    endcase
  end

  // ----------------------------------------
  // DRAM write with byte enables
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (dram_we) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (dec_be_i[b]) begin
          dram_q[dec_index_i][8*b +: 8] <= dec_wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exe_valid_o <= 1'b0;
    end else begin
      exe_valid_o <= dec_valid_i;
    end
  end

  // Target and op travel with the data
  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      exe_target_o <= dec_target_i;
      exe_op_o     <= dec_op_i;
      exe_rdata_o  <= rdata;
    end
  end

endmodule

// ==== testbench/soc_fabric_chk.sv ====
// Fabric credit assertions
`timescale 1ns/1ps

module soc_fabric_chk (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             req_valid_i,
  input logic             req_credit_i,
  input logic             rsp_valid_i,
  input fabric_pkg::rsp_e rsp_code_i,
  input logic             rsp_credit_i
);
  import fabric_pkg::*;

  int          req_out_q;
  int unsigned rsp_out_q;

  // Outstanding requests and unconsumed responses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_out_q <= 0;
      rsp_out_q <= 0;
    end else begin
      req_out_q <= req_out_q + int'(req_valid_i) - int'(req_credit_i);
      rsp_out_q <= rsp_out_q + 32'(rsp_valid_i) - 32'(rsp_credit_i);
    end
  end

  rsp_credit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> rsp_out_q < RspCredits)
    else $error("response sent without a free response credit");

  // A credit returned for no accepted request drives the count below zero
  req_credit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_out_q >= 0 && req_out_q <= int'(ReqCredits))
    else $error("request credits out of step with accepted requests");

  rsp_code_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> !$isunknown(rsp_code_i))
    else $error("response code unknown while valid");

endmodule

bind soc_fabric soc_fabric_chk u_chk (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .req_valid_i  ( req_valid_i  ),
  .req_credit_i ( req_credit_o ),
  .rsp_valid_i  ( rsp_valid_o  ),
  .rsp_code_i   ( rsp_code_o   ),
  .rsp_credit_i ( rsp_credit_i )
);

// ==== testbench/tb_soc_fabric.sv ====
// Fabric directed testbench
`timescale 1ns/1ps

module tb_soc_fabric;
  import fabric_pkg::*;

  `include "bootrom_image.svh"

  // Roughly ten times the length of all tests together
  localparam int TimeoutCycles = 4000;

  logic  clk_i;
  logic  rst_ni;
  logic  req_valid_i;
  op_e   req_op_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  be_t   req_be_i;
  logic  req_credit_o;
  logic  rsp_valid_o;
  rsp_e  rsp_code_o;
  data_t rsp_rdata_o;
  logic  rsp_credit_i;

  rsp_e  exp_code_q [$];
  data_t exp_data_q [$];
  data_t dram_model [DramWords];
  int    req_credits;
  int    pending_credits;
  int    rsp_seen;
  int    credit_seen;
  int    cycle_cnt;
  logic  hold_credits;

  soc_fabric uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Failure reporting and compares
  // ----------------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_code(input rsp_e got, input rsp_e exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns: %s code %s, expected %s",
                          $time, what, got.name(), exp.name()));
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0d ns: %s data %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("[FAIL] %0d ns: %s %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TimeoutCycles) begin
        abort_run($sformatf("Timeout: tests still running after %0d cycles", cycle_cnt));
      end
    end
  end

  // Receiver model, also collects returned request credits
  initial begin : receiver
    int gap;
    gap = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (!hold_credits && pending_credits > 0 && gap == 0) begin
        rsp_credit_i = 1'b1;
        pending_credits = pending_credits - 1;
        gap = 2;
      end else begin
        rsp_credit_i = 1'b0;
        if (gap > 0) gap = gap - 1;
      end
      @(negedge clk_i);
      if (req_credit_o) begin
        req_credits = req_credits + 1;
        credit_seen = credit_seen + 1;
      end
      if (rsp_valid_o) begin
        if (exp_code_q.size() == 0) begin
          abort_run("Response arrived while no request was outstanding");
        end else begin
          check_code(rsp_code_o, exp_code_q.pop_front(), $sformatf("response %0d", rsp_seen));
          check_data(rsp_rdata_o, exp_data_q.pop_front(), $sformatf("response %0d", rsp_seen));
          rsp_seen = rsp_seen + 1;
          pending_credits = pending_credits + 1;
        end
      end
    end
  end

  // ----------------------------------------
  // Requester side
  // ----------------------------------------
  function automatic addr_t rom_addr(input int i);
    return RomBase + addr_t'(8 * i);
  endfunction

  function automatic addr_t dram_addr(input int i);
    return DramBase + addr_t'(8 * i);
  endfunction

  function automatic data_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input be_t be);
    data_t res;
    res = old_word;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // One request, sent only while a credit is held
  task automatic send_req(input op_e op, input addr_t addr, input data_t wdata, input be_t be,
                          input rsp_e code, input data_t rdata);
    @(posedge clk_i);
    #1;
    while (req_credits == 0) begin
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    req_credits = req_credits - 1;
    exp_code_q.push_back(code);
    exp_data_q.push_back(rdata);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic read_word(input addr_t addr, input rsp_e code, input data_t rdata);
    send_req(OP_READ, addr, '0, '0, code, rdata);
  endtask

  task automatic write_dram(input int idx, input data_t wdata, input be_t be);
    dram_model[idx] = merge_bytes(dram_model[idx], wdata, be);
    send_req(OP_WRITE, dram_addr(idx), wdata, be, RSP_OKAY, '0);
  endtask

  task automatic wait_idle();
    @(posedge clk_i);
    while (exp_code_q.size() != 0 || pending_credits != 0 || req_credits != ReqCredits) begin
      @(posedge clk_i);
    end
    #1;
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic rom_read_sweep();
    for (int i = 0; i < RomWords; i++) begin
      read_word(rom_addr(i), RSP_OKAY, BOOTROM_IMAGE[i]);
    end
    // Low address bits ignored
    read_word(rom_addr(7) + 32'd6, RSP_OKAY, BOOTROM_IMAGE[7]);
    wait_idle();
  endtask

  task automatic dram_round_trip();
    int idx [5];
    idx = '{0, 1, 37, 128, 255};
    foreach (idx[k]) begin
      write_dram(idx[k], rand_word(), '1);
    end
    foreach (idx[k]) begin
      read_word(dram_addr(idx[k]), RSP_OKAY, dram_model[idx[k]]);
    end
    read_word(dram_addr(37) + 32'd3, RSP_OKAY, dram_model[37]);
    wait_idle();
  endtask

  task automatic byte_enable_merge();
    be_t be;
    for (int r = 0; r < 4; r++) begin
      write_dram(200 + r, rand_word(), '1);
      be = be_t'($urandom());
      write_dram(200 + r, rand_word(), be);
      read_word(dram_addr(200 + r), RSP_OKAY, dram_model[200 + r]);
    end
    wait_idle();
  endtask

  task automatic error_responses();
    read_word(32'h4000_0000, RSP_DECERR, '0);
    send_req(OP_WRITE, 32'h0000_0100, rand_word(), '1, RSP_DECERR, '0);
    // Just past each window
    read_word(rom_addr(RomWords), RSP_DECERR, '0);
    read_word(dram_addr(DramWords), RSP_DECERR, '0);
    send_req(OP_WRITE, rom_addr(2), rand_word(), '1, RSP_SLVERR, '0);
    read_word(rom_addr(2), RSP_OKAY, BOOTROM_IMAGE[2]);
    wait_idle();
  endtask

  task automatic backpressure_order();
    int base_rsp;
    int base_cred;
    int held_rsp;
    int held_cred;
    wait_idle();
    @(negedge clk_i);
    hold_credits = 1'b1;
    base_rsp  = rsp_seen;
    base_cred = credit_seen;
    read_word(rom_addr(5), RSP_OKAY, BOOTROM_IMAGE[5]);
    write_dram(10, rand_word(), '1);
    read_word(dram_addr(10), RSP_OKAY, dram_model[10]);
    read_word(32'h0000_0000, RSP_DECERR, '0);
    repeat (20) @(posedge clk_i);
    held_rsp  = rsp_seen - base_rsp;
    held_cred = credit_seen - base_cred;
    check_count(held_rsp, RspCredits, "responses while credits held");
    check_count(held_cred, RspCredits, "request credits while responses held");
    repeat (10) @(posedge clk_i);
    check_count(rsp_seen - base_rsp, held_rsp, "responses once stalled");
    check_count(credit_seen - base_cred, held_cred, "request credits once stalled");
    hold_credits = 1'b0;
    wait_idle();
  endtask

  initial begin : main
    void'($urandom(32'h3e4ea601));
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = OP_READ;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    req_be_i        = '0;
    rsp_credit_i    = 1'b0;
    hold_credits    = 1'b0;
    req_credits     = ReqCredits;
    pending_credits = 0;
    rsp_seen        = 0;
    credit_seen     = 0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    if (rsp_valid_o !== 1'b0 || req_credit_o !== 1'b0) begin
      abort_run("Response or credit output active right after reset");
    end
    rom_read_sweep();
    dram_round_trip();
    byte_enable_merge();
    error_responses();
    backpressure_order();
    $display("TEST PASSED");
    $finish;
  end

endmodule
